/* Makefile */
# Verilator build and run for the KS-10 memory subsystem

VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = memSubsysTb
FILELIST   = ks10mem.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = TESTS FAILED
PASS_MSG   = TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* ks10mem.f */
verilog/memPkg.sv
verilog/busArbiter.sv
verilog/memStatReg.sv
verilog/memCtrl.sv
verilog/wordRam.sv
verilog/memSubsys.sv
tb/memSubsys_asserts.sv
tb/memSubsysTb.sv

/* tb/memSubsysTb.sv */
////////////////////////////////////////
// Testbench for the KS-10 memory subsystem
// Directed tests through CPU and console ports
////////////////////////////////////////

`default_nettype none

module memSubsysTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int   ADDR_WIDTH   = 10;
   localparam int   RAM_WORDS    = 2 ** ADDR_WIDTH;
   localparam int   PERIOD       = 40;
   localparam int   RESET_CYCLES = 16;
   localparam int   DRIVE_DELAY  = 2;                 // After the rising edge
   localparam int   ACK_LATENCY  = 5;                 // Grant plus four phases
   localparam int   ACK_LIMIT    = 4 * memPkg::NXM_CYCLES;
   localparam int   NUM_XFERS    = 66;                // Bus cycles over all tests
   localparam int   TEST_CYCLES  = RESET_CYCLES + NUM_XFERS * 2 * memPkg::NXM_CYCLES;
   localparam logic CPU_PORT     = 1'b0;
   localparam logic CON_PORT     = 1'b1;

   logic            clk;
   logic            rstN;
   memPkg::busReq_t cpuReq;
   memPkg::busReq_t conReq;
   memPkg::busRsp_t cpuRsp;
   memPkg::busRsp_t conRsp;

   int              seed;
   memPkg::word_t   model [RAM_WORDS];              // Expected RAM contents
   memPkg::word_t   msrModel;                       // Expected MSR
   logic            lastCon;                        // Console served last

   memSubsys #(.ADDR_WIDTH(ADDR_WIDTH)) i_memSubsys
   (
      .clk    (clk),
      .rstN   (rstN),
      .cpuReq (cpuReq),
      .conReq (conReq),
      .cpuRsp (cpuRsp),
      .conRsp (conRsp)
   );

   always #(PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////
   // Checks and stimulus helpers

   task automatic expectWord(input memPkg::word_t got, input memPkg::word_t exp,
                             input string what);
      assert (got === exp)
      else
      begin
         $display("FAIL %0t: %s, got %012o expected %012o", $time, what, got, exp);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic expectCount(input int got, input int exp, input string what);
      assert (got == exp)
      else
      begin
         $display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, exp);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   function automatic memPkg::word_t randWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      return {hi[3:0], lo};
   endfunction

   function automatic logic [0:19] randAddr();
      logic [31:0] r;
      r = $random(seed);
      return 20'(r % RAM_WORDS);                    // Inside the RAM
   endfunction

   // Only the low ADDR_WIDTH bits select a word
   function automatic int ramIndex(input logic [0:19] addr);
      return int'(addr) % RAM_WORDS;
   endfunction

   function automatic memPkg::busAddr_t memRef(input logic rd, input logic wt,
                                               input logic wr, input logic [0:19] addr);
      memPkg::busAddr_t a;
      a = '0;
      a.mem.flags.read      = rd;
      a.mem.flags.writeTest = wt;
      a.mem.flags.write     = wr;
      a.mem.flags.phys      = 1'b1;
      a.mem.addr            = addr;
      return a;
   endfunction

   function automatic memPkg::busAddr_t ioRef(input logic rd, input logic wr,
                                              input logic [0:3] dev, input logic [0:17] addr);
      memPkg::busAddr_t a;
      a = '0;
      a.io.flags.read  = rd;
      a.io.flags.write = wr;
      a.io.flags.phys  = 1'b1;
      a.io.flags.io    = 1'b1;
      a.io.dev         = dev;
      a.io.addr        = addr;
      return a;
   endfunction

   // One full handshake on one master port
   task automatic busCycle(input logic useCon, input memPkg::busAddr_t addr,
                           input memPkg::word_t wrData, output memPkg::word_t rdData,
                           output logic nxm, output int latency);
      memPkg::busReq_t req;
      memPkg::busRsp_t rsp;
      req.req  = 1'b1;
      req.addr = addr;
      req.data = wrData;
      rsp      = '0;
      latency  = 0;
      @(posedge clk);
      #DRIVE_DELAY;
      if (useCon)
         conReq = req;
      else
         cpuReq = req;
      while (!rsp.ack)
      begin
         @(posedge clk);
         latency++;                                 // Rising edges since request
         @(negedge clk);
         rsp = useCon ? conRsp : cpuRsp;
         assert (latency <= ACK_LIMIT)
         else
         begin
            $display("No acknowledge on port %0d after %0d cycles", useCon, latency);
            $display("TESTS FAILED");
            $fatal(1);
         end
      end
      rdData  = rsp.data;
      nxm     = rsp.nxm;
      lastCon = useCon;
      @(posedge clk);                               // Drop in the cycle after ack
      #DRIVE_DELAY;
      if (useCon)
         conReq = '0;
      else
         cpuReq = '0;
   endtask

   task automatic writeWord(input logic useCon, input logic [0:19] addr,
                            input memPkg::word_t data);
      memPkg::word_t rd;
      logic          nxm;
      int            lat;
      busCycle(useCon, memRef(1'b0, 1'b0, 1'b1, addr), data, rd, nxm, lat);
      expectCount(int'(nxm), 0, "NXM on memory write");
      model[ramIndex(addr)] = data;
   endtask

   task automatic readAndCompare(input logic useCon, input logic [0:19] addr,
                                 input string what);
      memPkg::word_t rd;
      logic          nxm;
      int            lat;
      busCycle(useCon, memRef(1'b1, 1'b0, 1'b0, addr), '0, rd, nxm, lat);
      expectWord(rd, model[ramIndex(addr)], what);
      expectCount(int'(nxm), 0, "NXM on memory read");
      expectCount(lat, ACK_LATENCY, "uncontended latency");
   endtask

   task automatic msrAccess(input logic wr, input memPkg::word_t data);
      memPkg::word_t rd;
      logic          nxm;
      int            lat;
      busCycle(CON_PORT, ioRef(!wr, wr, memPkg::MEM_DEV, memPkg::MSR_ADDR), data,
               rd, nxm, lat);
      expectCount(int'(nxm), 0, "NXM on MSR access");
      expectCount(lat, ACK_LATENCY, "MSR latency");
      if (wr)
         msrModel = data & memPkg::MSR_WRITE_MASK;  // Unwritable bits stay zero
      else
         expectWord(rd, msrModel, "MSR read data");
   endtask

   task automatic nxmRead(input logic useCon, input logic [0:3] dev,
                          input logic [0:17] ioAddr);
      memPkg::word_t rd;
      logic          nxm;
      int            lat;
      busCycle(useCon, ioRef(1'b1, 1'b0, dev, ioAddr), '0, rd, nxm, lat);
      expectCount(int'(nxm), 1, "NXM flag");
      expectWord(rd, '0, "NXM read data");
      expectCount(lat, memPkg::NXM_CYCLES, "NXM timeout cycles");
   endtask

   ////////////////////////////////////////
   // Directed tests

   task automatic writeReadBack();
      logic [0:19] addrs [16];
      for (int i = 0; i < 16; i++)
      begin
         addrs[i] = randAddr();
         writeWord(CPU_PORT, addrs[i], randWord());
      end
      for (int i = 0; i < 16; i++)
         readAndCompare(CON_PORT, addrs[i], "read back");
   endtask

   task automatic writeTestSwap();
      logic [0:19]   addr;
      memPkg::word_t newWord;
      memPkg::word_t rd;
      logic          nxm;
      int            lat;
      for (int i = 0; i < 4; i++)
      begin
         addr = randAddr();
         writeWord(CPU_PORT, addr, randWord());
         newWord = randWord();
         busCycle(CPU_PORT, memRef(1'b0, 1'b1, 1'b0, addr), newWord, rd, nxm, lat);
         expectWord(rd, model[ramIndex(addr)], "write-test old word");
         expectCount(int'(nxm), 0, "NXM on write-test");
         model[ramIndex(addr)] = newWord;
         readAndCompare(CON_PORT, addr, "read after write-test");
      end
   endtask

   task automatic msrRegister();
      logic [0:19] aliasAddr;
      aliasAddr = {2'b00, memPkg::MSR_ADDR};       // RAM word with the MSR's low bits
      writeWord(CPU_PORT, aliasAddr, randWord());
      msrAccess(1'b0, '0);                         // Still zero from reset
      msrAccess(1'b1, '1);
      msrAccess(1'b0, '0);
      msrAccess(1'b1, randWord());
      msrAccess(1'b0, '0);
      readAndCompare(CON_PORT, aliasAddr, "RAM under MSR address");
   endtask

   task automatic nxmTimeout();
      logic [0:19] addr;
      nxmRead(CPU_PORT, 4'd3, memPkg::MSR_ADDR);  // No such device
      nxmRead(CON_PORT, memPkg::MEM_DEV, 18'o100004);
      addr = randAddr();
      writeWord(CPU_PORT, addr, randWord());
      readAndCompare(CON_PORT, addr, "read after NXM");
   endtask

   task automatic portContention();
      logic [0:19]   cpuAddr;
      logic [0:19]   conAddr;
      memPkg::word_t cpuRd;
      memPkg::word_t conRd;
      logic          cpuNxm;
      logic          conNxm;
      int            cpuLat;
      int            conLat;
      logic          expWinner;
      logic          winner;
      logic          firstWinner;
      for (int round = 0; round < 2; round++)
      begin
         cpuAddr = randAddr();
         conAddr = cpuAddr ^ 20'd1;
         // Write order picks the port served last, so the winner alternates
         if (round == 0)
         begin
            writeWord(CON_PORT, conAddr, randWord());
            writeWord(CPU_PORT, cpuAddr, randWord());
         end
         else
         begin
            writeWord(CPU_PORT, cpuAddr, randWord());
            writeWord(CON_PORT, conAddr, randWord());
         end
         expWinner = !lastCon;                      // Priority to the other master
         fork
            busCycle(CPU_PORT, memRef(1'b1, 1'b0, 1'b0, cpuAddr), '0, cpuRd, cpuNxm, cpuLat);
            busCycle(CON_PORT, memRef(1'b1, 1'b0, 1'b0, conAddr), '0, conRd, conNxm, conLat);
         join
         expectWord(cpuRd, model[ramIndex(cpuAddr)], "CPU data under contention");
         expectWord(conRd, model[ramIndex(conAddr)], "console data under contention");
         expectCount(int'(cpuNxm | conNxm), 0, "NXM under contention");
         winner = (conLat < cpuLat);
         expectCount(int'(winner), int'(expWinner), "first winner port");
         expectCount(winner ? conLat : cpuLat, ACK_LATENCY, "winner latency");
         if (round == 0)
            firstWinner = winner;
         else
            expectCount(int'(winner != firstWinner), 1, "winner alternation");
      end
   endtask

   task automatic addressWrap();
      logic [0:19] base;
      logic [0:19] wide;
      logic [0:19] highBits;
      highBits = 20'hFFFFF << ADDR_WIDTH;          // Everything above the RAM
      base     = randAddr();
      wide     = base | highBits;
      writeWord(CPU_PORT, wide, randWord());
      readAndCompare(CON_PORT, base, "wrapped address");
      readAndCompare(CPU_PORT, wide, "full address");
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog

   initial
   begin
      $timeformat(-9, 1, " ns", 0);
      seed     = 32'hd76c_da0c;
      clk      = 1'b0;
      rstN     = 1'b0;
      cpuReq   = '0;
      conReq   = '0;
      msrModel = '0;
      lastCon  = CON_PORT;                          // Nobody served yet
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rstN = 1'b1;
      writeReadBack();
      writeTestSwap();
      msrRegister();
      nxmTimeout();
      portContention();
      addressWrap();
      if ((i_memSubsys.uAsserts.ackFails + i_memSubsys.uAsserts.grantFails +
           i_memSubsys.uAsserts.weFails) == 0)
         $display("TESTS PASSED");
      else
      begin
         $display("Bound assertions failed during the run");
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial
   begin
      #((2 * TEST_CYCLES + memPkg::NXM_CYCLES) * PERIOD);
      $display("Timeout, the tests did not finish in the expected time");
      $display("TESTS FAILED");
      $fatal(1);
   end

endmodule

`default_nettype wire

/* tb/memSubsys_asserts.sv */
////////////////////////////////////////
// Bound checks on backplane and RAM controls
////////////////////////////////////////

`default_nettype none

module memSubsys_asserts
(
   input wire logic            clk,
   input wire logic            rstN,
   input wire memPkg::busRsp_t cpuRsp,
   input wire memPkg::busRsp_t conRsp,
   input wire logic [1:0]      grant,
   input wire memPkg::busReq_t memReq,
   input wire logic            ramWe
);

   timeunit 1ns;
   timeprecision 100ps;

   logic anyAck;                          // Ack on either port
   int   ackFails   = 0;
   int   grantFails = 0;
   int   weFails    = 0;

   assign anyAck = cpuRsp.ack || conRsp.ack;

   // Ack is a one-cycle pulse
   ackPulse: assert property (@(posedge clk) disable iff (!rstN) anyAck |=> !anyAck)
   else
   begin
      $error("Acknowledge held for more than one cycle");
      ackFails++;
   end

   grantOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant))
   else
   begin
      $error("Arbiter grant is not one-hot or zero");
      grantFails++;
   end

   // No RAM write on an I/O reference
   weMemOnly: assert property (@(posedge clk) disable iff (!rstN)
                               ramWe |-> !memReq.addr.mem.flags.io)
   else
   begin
      $error("RAM write enable during an I/O reference");
      weFails++;
   end

endmodule

bind memSubsys memSubsys_asserts uAsserts
(
   .clk    (clk),
   .rstN   (rstN),
   .cpuRsp (cpuRsp),
   .conRsp (conRsp),
   .grant  (uArb.grant),
   .memReq (memReq),
   .ramWe  (ramWe)
);

`default_nettype wire

/* verilog/busArbiter.sv */
////////////////////////////////////////
// Backplane arbiter, CPU and console ports
// Round robin grant plus NXM timeout
////////////////////////////////////////

`default_nettype none

module busArbiter
(
   input  wire logic            clk,
   input  wire logic            rstN,
   input  wire memPkg::busReq_t cpuReq,
   input  wire memPkg::busReq_t conReq,
   output memPkg::busRsp_t      cpuRsp,
   output memPkg::busRsp_t      conRsp,
   output memPkg::busReq_t      memReq,
   input  wire memPkg::busRsp_t memRsp
);

   localparam int NXM_W = $clog2(memPkg::NXM_CYCLES + 1);

   logic [1:0]       grant;               // Bit 0 CPU, bit 1 console
   logic             lastCon;             // Console won last
   logic [NXM_W-1:0] nxmCnt;              // Cycles since grant
   logic             nxmHit;              // Timeout, nobody answered
   memPkg::busRsp_t  rsp;

   // Nothing acknowledged by the last cycle of the window
   assign nxmHit = (grant != 2'b00) && !memRsp.ack &&
                   (nxmCnt == NXM_W'(memPkg::NXM_CYCLES));

   always_comb
   begin
      rsp = memRsp;
      if (nxmHit)
      begin
         rsp.ack  = 1'b1;                 // Force the end of the cycle
         rsp.nxm  = 1'b1;
         rsp.data = '0;
      end
   end

   ////////////////////////////////////////
   // Request forwarding and response steering

   always_comb
   begin
      memReq = '0;                        // Idle bus when nothing granted
      if (grant[0])
         memReq = cpuReq;
      else if (grant[1])
         memReq = conReq;
   end

   assign cpuRsp = grant[0] ? rsp : '0;
   assign conRsp = grant[1] ? rsp : '0;

   // Grant only from idle, drop it on acknowledge
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         grant   <= 2'b00;
         lastCon <= 1'b1;                 // CPU has first priority
         nxmCnt  <= '0;
      end
      else if (grant == 2'b00)
      begin
         nxmCnt <= NXM_W'(1);             // Grant cycle counts as one
         if (cpuReq.req && (!conReq.req || lastCon))
         begin
            grant   <= 2'b01;
            lastCon <= 1'b0;
         end
         else if (conReq.req)
         begin
            grant   <= 2'b10;
            lastCon <= 1'b1;
         end
      end
      else if (rsp.ack)
         grant <= 2'b00;                  // Done, normal or NXM
      else
         nxmCnt <= nxmCnt + NXM_W'(1);
   end

endmodule

`default_nettype wire

/* verilog/memCtrl.sv */
////////////////////////////////////////
// Backplane to RAM memory controller
// Address decode, 4-phase sequencer, data mux
////////////////////////////////////////

`default_nettype none

module memCtrl
#(
   parameter int ADDR_WIDTH = 10
)
(
   input  wire logic            clk,
   input  wire logic            rstN,
   input  wire memPkg::busReq_t memReq,
   output memPkg::busRsp_t      memRsp,
   output logic [ADDR_WIDTH-1:0] ramAddr,
   output logic                 ramWe,
   output memPkg::word_t        ramWrData,
   input  wire memPkg::word_t   ramRdData,
   output logic                 msrWrite,
   output memPkg::word_t        msrWrData,
   input  wire memPkg::word_t   msrValue
);

   localparam logic [1:0] PH1 = 2'd0;
   localparam logic [1:0] PH2 = 2'd1;
   localparam logic [1:0] PH3 = 2'd2;
   localparam logic [1:0] PH4 = 2'd3;

   memPkg::busFlags_t flags;
   logic              msrHit;             // Device 0, MSR address
   logic              memRead;
   logic              memWrite;
   logic              memWrTest;
   logic              msrRd;
   logic              msrWr;
   logic              decoded;            // Any reference we answer
   logic              busy;               // Sequencer running
   logic [1:0]        phase;
   memPkg::word_t     rdReg;              // RAM data captured in phase 3

   ////////////////////////////////////////
   // Address decode

   assign flags  = memReq.addr.mem.flags;
   assign msrHit = flags.io && flags.phys &&
                   (memReq.addr.io.dev == memPkg::MEM_DEV) &&
                   (memReq.addr.io.addr == memPkg::MSR_ADDR);

   assign memRead   = flags.read      && !flags.io;
   assign memWrite  = flags.write     && !flags.io;
   assign memWrTest = flags.writeTest && !flags.io;
   assign msrRd     = flags.read      && msrHit;
   assign msrWr     = flags.write     && msrHit;
   assign decoded   = memRead || memWrite || memWrTest || msrRd || msrWr;

   // Phase counter, starts one cycle after the grant
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         busy  <= 1'b0;
         phase <= PH1;
      end
      else if (!memReq.req)
         busy <= 1'b0;                    // Aborted, request dropped
      else if (!busy)
      begin
         busy  <= decoded;                // Unknown refs left to NXM timer
         phase <= PH1;
      end
      else if (phase == PH4)
         busy <= 1'b0;
      else
         phase <= phase + 2'd1;
   end

   always_ff @(posedge clk)
   begin
      if (busy && (phase == PH3))
         rdReg <= ramRdData;
   end

   ////////////////////////////////////////
   // RAM and MSR controls

   // Low address bits only, upper bits wrap
   assign ramAddr   = memReq.addr.mem.addr[20-ADDR_WIDTH +: ADDR_WIDTH];
   assign ramWrData = memReq.data;
   assign ramWe     = busy && ((memWrite  && (phase == PH2)) ||
                               (memWrTest && (phase == PH4)));   // Old word already held
   assign msrWrite  = busy && msrWr && (phase == PH4);
   assign msrWrData = memReq.data;

   // Acknowledge in phase 4, io flag picks the source
   always_comb
   begin
      memRsp     = '0;
      memRsp.ack = busy && (phase == PH4);
      if (memRsp.ack)
         memRsp.data = flags.io ? msrValue : rdReg;
   end

endmodule

`default_nettype wire

/* verilog/memPkg.sv */
////////////////////////////////////////
// KS-10 memory subsystem definitions
// Bus word, address views, handshake types
////////////////////////////////////////

`default_nettype none

package memPkg;

   // One 36-bit word, bit 0 is the MSB as on the KS-10
   typedef logic [0:35] word_t;

   // Flag bits 0..13 of the address word
   typedef struct packed
   {
      logic       read;                  // Read cycle
      logic       writeTest;             // Read old word, write new one
      logic       write;                 // Write cycle
      logic       phys;                  // Physical reference
      logic       io;                    // I/O reference
      logic [0:8] spare;                 // Unused flags
   } busFlags_t;

   // Memory view: flags, 2 unused bits, 20-bit address
   typedef struct packed
   {
      busFlags_t   flags;
      logic [0:1]  unused;
      logic [0:19] addr;
   } memAddr_t;

   // I/O view: flags, device number, 18-bit I/O address
   typedef struct packed
   {
      busFlags_t   flags;
      logic [0:3]  dev;
      logic [0:17] addr;
   } ioAddr_t;

   // Same address word, decoded either way
   typedef union packed
   {
      memAddr_t mem;
      ioAddr_t  io;
   } busAddr_t;

   ////////////////////////////////////////
   // Backplane request and response

   typedef struct packed
   {
      logic     req;                     // Held until acknowledge
      busAddr_t addr;
      word_t    data;                    // Write data
   } busReq_t;

   typedef struct packed
   {
      logic  ack;                        // One-cycle pulse
      logic  nxm;                        // Nonexistent memory
      word_t data;                       // Read data
   } busRsp_t;

   ////////////////////////////////////////
   // Constants

   localparam logic [0:3]  MEM_DEV        = 4'd0;              // Controller is device 0
   localparam logic [0:17] MSR_ADDR       = 18'o100000;        // MSR I/O address
   localparam word_t       MSR_WRITE_MASK = 36'o7777_0000_7777; // Bits 0-11, 24-35
   localparam int          NXM_CYCLES     = 8;                 // Ack timeout in cycles

endpackage

`default_nettype wire

/* verilog/memStatReg.sv */
////////////////////////////////////////
// Memory Status Register, device 0
////////////////////////////////////////

`default_nettype none

module memStatReg
(
   input  wire logic          clk,
   input  wire logic          rstN,
   input  wire logic          msrWrite,   // Strobe from controller
   input  wire memPkg::word_t msrWrData,
   output memPkg::word_t      msrValue
);

   // Only masked bits are stored, the rest read zero
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         msrValue <= '0;
      else if (msrWrite)
         msrValue <= msrWrData & memPkg::MSR_WRITE_MASK;
   end

endmodule

`default_nettype wire

/* verilog/memSubsys.sv */
////////////////////////////////////////
// Memory subsystem top level
// Two masters, arbiter, controller, MSR, RAM
////////////////////////////////////////

`default_nettype none

module memSubsys
#(
   parameter int ADDR_WIDTH = 10
)
(
   input  wire logic            clk,
   input  wire logic            rstN,
   input  wire memPkg::busReq_t cpuReq,
   input  wire memPkg::busReq_t conReq,
   output memPkg::busRsp_t      cpuRsp,
   output memPkg::busRsp_t      conRsp
);

   memPkg::busReq_t       memReq;         // Granted request
   memPkg::busRsp_t       memRsp;
   logic [ADDR_WIDTH-1:0] ramAddr;
   logic                  ramWe;
   memPkg::word_t         ramWrData;
   memPkg::word_t         ramRdData;
   logic                  msrWrite;
   memPkg::word_t         msrWrData;
   memPkg::word_t         msrValue;

   busArbiter uArb
   (
      .clk    (clk),
      .rstN   (rstN),
      .cpuReq (cpuReq),
      .conReq (conReq),
      .cpuRsp (cpuRsp),
      .conRsp (conRsp),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   memCtrl #(.ADDR_WIDTH(ADDR_WIDTH)) uCtrl
   (
      .clk       (clk),
      .rstN      (rstN),
      .memReq    (memReq),
      .memRsp    (memRsp),
      .ramAddr   (ramAddr),
      .ramWe     (ramWe),
      .ramWrData (ramWrData),
      .ramRdData (ramRdData),
      .msrWrite  (msrWrite),
      .msrWrData (msrWrData),
      .msrValue  (msrValue)
   );

   memStatReg uMsr
   (
      .clk       (clk),
      .rstN      (rstN),
      .msrWrite  (msrWrite),
      .msrWrData (msrWrData),
      .msrValue  (msrValue)
   );

   wordRam #(.ADDR_WIDTH(ADDR_WIDTH)) uRam
   (
      .clk       (clk),
      .ramAddr   (ramAddr),
      .ramWe     (ramWe),
      .ramWrData (ramWrData),
      .ramRdData (ramRdData)
   );

endmodule

`default_nettype wire

/* verilog/wordRam.sv */
////////////////////////////////////////
// Single-port 36-bit word RAM
// Registered read, one-cycle latency
////////////////////////////////////////

`default_nettype none

module wordRam
#(
   parameter int ADDR_WIDTH = 10
)
(
   input  wire logic                  clk,
   input  wire logic [ADDR_WIDTH-1:0] ramAddr,
   input  wire logic                  ramWe,
   input  wire memPkg::word_t         ramWrData,
   output memPkg::word_t              ramRdData
);

   memPkg::word_t mem [2**ADDR_WIDTH];    // Stands in for the SSRAM

   // Read-first on a write cycle
   always_ff @(posedge clk)
   begin
      if (ramWe)
         mem[ramAddr] <= ramWrData;
      ramRdData <= mem[ramAddr];
   end

endmodule

`default_nettype wire
